// ==== hdl/arch_defs_pkg.sv ====
package arch_defs_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    parameter int DATA_WIDTH = 8;               // Data bits per frame.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State and owner encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Shared by transmitter and receiver.
    typedef enum logic [1:0] {
        S_UART_TX_IDLE      = 2'd0,
        S_UART_TX_START     = 2'd1,
        S_UART_TX_SEND_DATA = 2'd2,
        S_UART_TX_STOP      = 2'd3
    } uart_fsm_state_t;

    // Client granted last by the arbiter.
    typedef enum logic {
        ARB_ECHO   = 1'b0,
        ARB_BEACON = 1'b1
    } arb_owner_t;

endpackage

// ==== hdl/uart_transmitter.sv ====
module uart_transmitter
    import arch_defs_pkg::*;
#(
    parameter int CLOCK_SPEED = 20_000_000,
    parameter int BAUD_RATE   = 9600
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [DATA_WIDTH-1:0] tx_parallel_in_data,
    input  logic                  tx_start_strobe,

    output logic                  busy_flag,
    output logic                  data_out
);

    localparam int CYCLES_PER_BIT = CLOCK_SPEED / BAUD_RATE;
    localparam int BAUD_W         = $clog2(CYCLES_PER_BIT);
    localparam int BIT_W          = $clog2(DATA_WIDTH);

    uart_fsm_state_t current_state, next_state;

    logic [DATA_WIDTH-1:0] tx_shift_reg;
    logic [BIT_W-1:0]      bit_count, next_bit_count;
    logic [BAUD_W-1:0]     baud_count, next_baud_count;
    logic                  bit_done;

    assign bit_done = (baud_count == BAUD_W'(CYCLES_PER_BIT - 1)); // Last cycle of a bit.

    always_comb begin
        next_state      = current_state;
        next_bit_count  = bit_count;
        next_baud_count = baud_count;
        data_out        = 1'b1;                 // Line idles high.
        busy_flag       = 1'b1;

        case (current_state)
            S_UART_TX_IDLE: begin
                busy_flag = tx_start_strobe;    // Busy already in the strobe cycle.
                if (tx_start_strobe) begin
                    next_state      = S_UART_TX_START;
                    next_baud_count = '0;
                    next_bit_count  = '0;
                end
            end

            S_UART_TX_START: begin
                data_out = 1'b0;
                if (bit_done) begin
                    next_state      = S_UART_TX_SEND_DATA;
                    next_baud_count = '0;
                end else begin
                    next_baud_count = baud_count + 1'b1;
                end
            end

            S_UART_TX_SEND_DATA: begin
                data_out = tx_shift_reg[0];     // LSB first.
                if (bit_done) begin
                    next_baud_count = '0;
                    next_bit_count  = bit_count + 1'b1;
                    if (bit_count == BIT_W'(DATA_WIDTH - 1)) begin
                        next_state = S_UART_TX_STOP;
                    end
                end else begin
                    next_baud_count = baud_count + 1'b1;
                end
            end

            S_UART_TX_STOP: begin
                if (bit_done) begin
                    next_state = S_UART_TX_IDLE;
                end else begin
                    next_baud_count = baud_count + 1'b1;
                end
            end

            default: next_state = S_UART_TX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_state <= S_UART_TX_IDLE;
            bit_count     <= '0;
            baud_count    <= '0;
        end else begin
            current_state <= next_state;
            bit_count     <= next_bit_count;
            baud_count    <= next_baud_count;
        end
    end

    always_ff @(posedge clk) begin
        if (current_state == S_UART_TX_IDLE && tx_start_strobe) begin
            tx_shift_reg <= tx_parallel_in_data;
        end else if (current_state == S_UART_TX_SEND_DATA && bit_done) begin
            tx_shift_reg <= {1'b1, tx_shift_reg[DATA_WIDTH-1:1]};
        end
    end

endmodule

// ==== hdl/uart_receiver.sv ====
module uart_receiver
    import arch_defs_pkg::*;
#(
    parameter int CLOCK_SPEED = 20_000_000,
    parameter int BAUD_RATE   = 9600
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  rx_line,

    output logic [DATA_WIDTH-1:0] rx_data,
    output logic                  rx_valid,
    output logic                  frame_error
);

    localparam int CYCLES_PER_BIT = CLOCK_SPEED / BAUD_RATE;
    localparam int HALF_BIT       = CYCLES_PER_BIT / 2;
    localparam int BAUD_W         = $clog2(CYCLES_PER_BIT);
    localparam int BIT_W          = $clog2(DATA_WIDTH);

    uart_fsm_state_t state;

    logic                  rx_meta, rx_sync, rx_prev;
    logic [DATA_WIDTH-1:0] rx_shift_reg;
    logic [BIT_W-1:0]      bit_count;
    logic [BAUD_W-1:0]     baud_count;
    logic                  half_done, bit_done;

    assign half_done = (baud_count == BAUD_W'(HALF_BIT - 1));
    assign bit_done  = (baud_count == BAUD_W'(CYCLES_PER_BIT - 1)); // Middle of next bit.
    assign rx_data   = rx_shift_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;                 // For falling edge detect.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_UART_TX_IDLE;
            baud_count  <= '0;
            bit_count   <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
            baud_count  <= baud_count + 1'b1;
            case (state)
                S_UART_TX_IDLE: begin
                    baud_count <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= S_UART_TX_START;
                    end
                end
                S_UART_TX_START: begin
                    if (half_done) begin
                        baud_count <= '0;
                        bit_count  <= '0;
                        // A high line here was a glitch.
                        state <= rx_sync ? S_UART_TX_IDLE : S_UART_TX_SEND_DATA;
                    end
                end
                S_UART_TX_SEND_DATA: begin
                    if (bit_done) begin
                        baud_count <= '0;
                        bit_count  <= bit_count + 1'b1;
                        if (bit_count == BIT_W'(DATA_WIDTH - 1)) begin
                            state <= S_UART_TX_STOP;
                        end
                    end
                end
                S_UART_TX_STOP: begin
                    if (bit_done) begin
                        rx_valid    <= rx_sync;
                        frame_error <= !rx_sync;
                        state       <= S_UART_TX_IDLE;
                    end
                end
                default: state <= S_UART_TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_UART_TX_SEND_DATA && bit_done) begin
            rx_shift_reg <= {rx_sync, rx_shift_reg[DATA_WIDTH-1:1]}; // LSB arrives first.
        end
    end

endmodule

// ==== hdl/echo_buffer.sv ====
module echo_buffer
    import arch_defs_pkg::*;
#(
    parameter int ECHO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [DATA_WIDTH-1:0] rx_data,
    input  logic                  rx_valid,
    input  logic                  echo_grant,

    output logic                  echo_req,
    output logic [DATA_WIDTH-1:0] echo_data,
    output logic                  echo_overflow
);

    localparam int ADDR_W = $clog2(ECHO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [ECHO_DEPTH];
    logic [ADDR_W-1:0]     wr_ptr, rd_ptr;
    logic [ADDR_W:0]       count;
    logic                  full, push, pop;

    assign full      = (count == (ADDR_W+1)'(ECHO_DEPTH));
    assign push      = rx_valid && !full;
    assign pop       = echo_grant && echo_req;
    assign echo_req  = (count != '0);
    assign echo_data = mem[rd_ptr];             // Head byte.

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            echo_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;        // Wraps at the power of two.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
            if (rx_valid && full) begin
                echo_overflow <= 1'b1;          // Sticky.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_data;
        end
    end

endmodule

// ==== hdl/beacon_source.sv ====
module beacon_source
    import arch_defs_pkg::*;
#(
    parameter int BEACON_PERIOD = 1000
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  beacon_grant,

    output logic                  beacon_req,
    output logic [DATA_WIDTH-1:0] beacon_data
);

    localparam int PERIOD_W = $clog2(BEACON_PERIOD + 1);

    logic [PERIOD_W-1:0]   period_count;
    logic [DATA_WIDTH-2:0] seq_num;

    assign beacon_data = {1'b1, seq_num};      // Top bit marks a beacon.

    always_ff @(posedge clk) begin
        if (reset) begin
            period_count <= '0;
            seq_num      <= '0;
            beacon_req   <= 1'b0;
        end else if (beacon_grant) begin
            period_count <= '0;
            seq_num      <= seq_num + 1'b1;
            beacon_req   <= 1'b0;
        end else if (!beacon_req) begin
            period_count <= period_count + 1'b1;
            if (period_count == PERIOD_W'(BEACON_PERIOD - 1)) begin
                beacon_req <= 1'b1;             // Holds until granted.
            end
        end
    end

endmodule

// ==== hdl/tx_arbiter.sv ====
module tx_arbiter
    import arch_defs_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  echo_req,
    input  logic [DATA_WIDTH-1:0] echo_data,
    input  logic                  beacon_req,
    input  logic [DATA_WIDTH-1:0] beacon_data,
    input  logic                  busy_flag,

    output logic                  echo_grant,
    output logic                  beacon_grant,
    output logic                  tx_start_strobe,
    output logic [DATA_WIDTH-1:0] tx_data
);

    arb_owner_t last_owner;

    logic can_issue;
    logic pick_beacon, pick_echo;

    // Own strobe keeps the busy path out of the loop.
    assign can_issue   = !busy_flag && !tx_start_strobe;
    assign pick_beacon = beacon_req && (!echo_req || last_owner == ARB_ECHO);
    assign pick_echo   = echo_req && !pick_beacon;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_owner      <= ARB_BEACON;      // Echo wins the first tie.
            echo_grant      <= 1'b0;
            beacon_grant    <= 1'b0;
            tx_start_strobe <= 1'b0;
        end else begin
            echo_grant      <= can_issue && pick_echo;
            beacon_grant    <= can_issue && pick_beacon;
            tx_start_strobe <= can_issue && (pick_echo || pick_beacon);
            if (can_issue && pick_echo) begin
                last_owner <= ARB_ECHO;
            end else if (can_issue && pick_beacon) begin
                last_owner <= ARB_BEACON;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_issue) begin
            tx_data <= pick_beacon ? beacon_data : echo_data;
        end
    end

endmodule

// ==== hdl/uart_echo_top.sv ====
module uart_echo_top
    import arch_defs_pkg::*;
#(
    parameter int CLOCK_SPEED   = 20_000_000,
    parameter int BAUD_RATE     = 9600,
    parameter int ECHO_DEPTH    = 4,
    parameter int BEACON_PERIOD = 200_000
) (
    input  logic clk,
    input  logic reset,
    input  logic rx_line,

    output logic tx_line,
    output logic tx_busy,
    output logic echo_overflow,
    output logic frame_error
);

    logic [DATA_WIDTH-1:0] rx_data, echo_data, beacon_data, tx_data;
    logic                  rx_valid;
    logic                  echo_req, echo_grant;
    logic                  beacon_req, beacon_grant;
    logic                  tx_start_strobe;

    uart_receiver #(.CLOCK_SPEED(CLOCK_SPEED), .BAUD_RATE(BAUD_RATE)) u_uart_receiver (
        .clk(clk), .reset(reset), .rx_line(rx_line),
        .rx_data(rx_data), .rx_valid(rx_valid), .frame_error(frame_error)
    );

    echo_buffer #(.ECHO_DEPTH(ECHO_DEPTH)) u_echo_buffer (
        .clk(clk), .reset(reset), .rx_data(rx_data), .rx_valid(rx_valid),
        .echo_grant(echo_grant), .echo_req(echo_req), .echo_data(echo_data),
        .echo_overflow(echo_overflow)
    );

    beacon_source #(.BEACON_PERIOD(BEACON_PERIOD)) u_beacon_source (
        .clk(clk), .reset(reset), .beacon_grant(beacon_grant),
        .beacon_req(beacon_req), .beacon_data(beacon_data)
    );

    tx_arbiter u_tx_arbiter (
        .clk(clk), .reset(reset),
        .echo_req(echo_req), .echo_data(echo_data),
        .beacon_req(beacon_req), .beacon_data(beacon_data),
        .busy_flag(tx_busy), .echo_grant(echo_grant), .beacon_grant(beacon_grant),
        .tx_start_strobe(tx_start_strobe), .tx_data(tx_data)
    );

    uart_transmitter #(.CLOCK_SPEED(CLOCK_SPEED), .BAUD_RATE(BAUD_RATE)) u_uart_transmitter (
        .clk(clk), .reset(reset),
        .tx_parallel_in_data(tx_data), .tx_start_strobe(tx_start_strobe),
        .busy_flag(tx_busy), .data_out(tx_line)
    );

endmodule

// ==== verification/uart_echo_tb.sv ====
module uart_echo_tb;

    localparam int BIT_CYCLES    = 16;
    localparam int BURST_MAX     = 64;
    localparam int FRAME_COUNT   = 6 + 1 + BURST_MAX;
    localparam int WATCHDOG_TIME = 40 * BIT_CYCLES * 10 * (FRAME_COUNT + 20) * 3;

    logic clk;
    logic reset;
    logic rx_line;
    logic tx_line;
    logic tx_busy;
    logic echo_overflow;
    logic frame_error;

    logic [7:0]  sent_bytes [$];
    logic [31:0] rng_state;
    logic [6:0]  beacon_seq        = '0;
    int          error_count       = 0;
    int          echo_count        = 0;
    int          beacon_count      = 0;
    int          frame_error_count = 0;
    int          beacon_mark       = 0;

    uart_echo_top #(
        .CLOCK_SPEED(1_600_000), .BAUD_RATE(100_000),
        .ECHO_DEPTH(4), .BEACON_PERIOD(600)
    ) u_uart_echo_top (
        .clk(clk), .reset(reset), .rx_line(rx_line),
        .tx_line(tx_line), .tx_busy(tx_busy),
        .echo_overflow(echo_overflow), .frame_error(frame_error)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic expect_value(input string name, input logic [7:0] got,
                                input logic [7:0] expected);
        assert (got === expected) else begin
            error_count++;
            $display("Fail %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic send_frame(input logic [7:0] value, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, value, 1'b0};
        if (stop_bit) begin
            sent_bytes.push_back(value);        // Only good frames echo.
        end
        for (int b = 0; b < 10; b++) begin
            @(posedge clk);
            #2;
            rx_line = bits[b];
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
        #2;
    endtask

    // Dropped bytes are skipped only while echo_overflow is set.
    task automatic check_echo(input logic [7:0] got);
        logic [7:0] expected;
        if (sent_bytes.size() == 0) begin
            error_count++;
            $display("Echo byte %h arrived with no sent byte left to match", got);
        end else begin
            while (sent_bytes.size() > 1 && sent_bytes[0] != got) begin
                if (!echo_overflow) begin
                    expect_value("echo byte", got, sent_bytes[0]);
                end
                expected = sent_bytes.pop_front();
            end
            expected = sent_bytes.pop_front();
            expect_value("echo byte", got, expected);
            echo_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial decoder and monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : tx_decoder
        logic [9:0] frame_bits;
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            if (tx_line === 1'b0) begin
                for (int i = 0; i < 10 * BIT_CYCLES; i++) begin
                    if (i > 0) begin
                        @(negedge clk);
                    end
                    expect_value("tx_busy", tx_busy, 8'h01);
                    if (i % BIT_CYCLES == BIT_CYCLES / 2) begin
                        frame_bits[i / BIT_CYCLES] = tx_line;   // Mid-bit sample.
                    end
                end
                expect_value("tx_line start bit", frame_bits[0], 8'h00);
                expect_value("tx_line stop bit", frame_bits[9], 8'h01);
                if (frame_bits[8]) begin
                    expect_value("beacon byte", frame_bits[8:1], {1'b1, beacon_seq});
                    beacon_seq++;
                    beacon_count++;
                end else begin
                    check_echo(frame_bits[8:1]);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (reset === 1'b0 && frame_error === 1'b1) begin
            frame_error_count++;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        rx_line   = 1'b1;
        rng_state = 32'h11a5_a552;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        expect_value("tx_line", tx_line, 8'h01);
        expect_value("tx_busy", tx_busy, 8'h00);
        expect_value("echo_overflow", echo_overflow, 8'h00);
        expect_value("frame_error", frame_error, 8'h00);

        repeat (6) begin
            rng_state = next_random(rng_state);
            send_frame({1'b0, rng_state[6:0]}, 1'b1);
            repeat (2 * BIT_CYCLES) @(posedge clk);
        end
        while (sent_bytes.size() != 0) begin
            @(posedge clk);                     // Wait for all echoes.
        end

        rng_state = next_random(rng_state);
        send_frame({1'b0, rng_state[6:0]}, 1'b0);
        @(posedge clk);
        #2;
        rx_line = 1'b1;
        repeat (400) @(posedge clk);
        expect_value("frame_error pulses", frame_error_count, 8'h01);

        // Back-to-back frames until the buffer overflows.
        beacon_mark = beacon_count;
        for (int n = 0; n < BURST_MAX && (n < 8 || !echo_overflow); n++) begin
            rng_state = next_random(rng_state);
            send_frame({1'b0, rng_state[6:0]}, 1'b1);
        end
        repeat (1600) @(posedge clk);
        expect_value("echo_overflow", echo_overflow, 8'h01);
        assert (beacon_count > beacon_mark) else begin
            error_count++;
            $display("No beacon byte appeared during the echo burst");
        end

        $display("Echo bytes %0d, beacon bytes %0d, frame errors %0d, errors %0d",
                 echo_count, beacon_count, frame_error_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/arch_defs_pkg.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/echo_buffer.sv
hdl/beacon_source.sv
hdl/tx_arbiter.sv
hdl/uart_echo_top.sv
verification/uart_echo_tb.sv
